/* verif/icache_stimulus.txt */
// op addr exp, all hex. op 0 idle, 1 read hit, 2 read miss, 3 read fault, 4 host return.
// exp is o_miss_addr one cycle after the result, or after the host return.
0 00000000 00000000
0 00000000 00000000
3 00010200 00000000
3 00020000 00000000
0 00000000 00000000
2 00010025 00010020
0 00000000 00010020
2 00010043 00010020
0 00000000 00010020
4 00010400 00010020
4 00010020 00000000
1 00010020 00000000
1 00010021 00000000
1 00010022 00000000
1 00010023 00000000
1 00010024 00000000
1 00010025 00000000
1 00010026 00000000
1 00010027 00000000
1 00010028 00000000
1 00010029 00000000
1 0001002a 00000000
1 0001002b 00000000
1 0001002c 00000000
1 0001002d 00000000
1 0001002e 00000000
1 0001002f 00000000
2 00010043 00010040
1 0001002a 00010040
3 00010300 00010040
2 00010055 00010040
0 00000000 00010040
4 00010040 00000000
1 00010043 00000000
1 0001004f 00000000
2 000101f0 000101f0
1 00010021 000101f0
3 00020000 000101f0
1 00010044 000101f0
0 00000000 000101f0

/* files.f */
src/icache_pkg.sv
src/fetch_decode.sv
src/icache_store.sv
src/refill_ctrl.sv
src/icache_top.sv
verif/icache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

# build, run, then decide pass or fail from the log.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/icache_tb.sv */
`timescale 1ns/1ns

module icache_tb;

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 5;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = 64;
    localparam int NUM_LINES      = 32;
    localparam int LINE_W         = icache_pkg::LINE_W;

    localparam logic [3:0] OP_IDLE   = 4'h0;
    localparam logic [3:0] OP_HIT    = 4'h1;
    localparam logic [3:0] OP_MISS   = 4'h2;
    localparam logic [3:0] OP_FAULT  = 4'h3;
    localparam logic [3:0] OP_HOST   = 4'h4;
    localparam logic [3:0] OP_BUBBLE = 4'hf;  // filler slot, request not tracked.

    logic              clk;
    logic              rst_n;
    logic [31:0]       i_addr;
    logic              i_rd;
    logic              i_host_rd_ready;
    logic [31:0]       i_host_rd_addr;
    logic [LINE_W-1:0] i_host_rd_data;
    logic [31:0]       o_rd_data;
    logic              o_miss;
    logic              o_segfault;
    logic              o_rd_req;
    logic [31:0]       o_miss_addr;

    logic [LINE_W-1:0]    model_line [NUM_LINES];
    logic [NUM_LINES-1:0] model_valid;
    logic [15:0]          lfsr;
    int                   check_errors;
    int                   timeout_errors;

    // slot 0 was driven last cycle, slot 1 has its result out, slot 2 its request.
    logic [3:0]  pipe_op   [3];
    logic [31:0] pipe_addr [3];
    logic [31:0] pipe_exp  [3];

    icache_top #(
        .NUM_LINES (NUM_LINES)
    ) u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_addr          (i_addr),
        .i_rd            (i_rd),
        .o_rd_data       (o_rd_data),
        .o_miss          (o_miss),
        .o_segfault      (o_segfault),
        .i_host_rd_ready (i_host_rd_ready),
        .i_host_rd_addr  (i_host_rd_addr),
        .i_host_rd_data  (i_host_rd_data),
        .o_rd_req        (o_rd_req),
        .o_miss_addr     (o_miss_addr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0])
            return (state >> 1) ^ 16'hb400;
        else
            return state >> 1;
    endfunction

    task automatic finish_run();
        $display("check errors: %0d, timeout errors: %0d", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%08h, expected 0x%08h at %0t ns", name, got, exp, $time);
            check_errors++;
        end
    endtask

    // data, miss and fault flags of the fetch driven two cycles ago.
    task automatic check_result(input logic [3:0] op, input logic [31:0] addr);
        logic [31:0] exp_data;
        int          line_idx;
        int          word_idx;
        line_idx = int'(addr[8:4]);
        word_idx = int'(addr[3:0]);
        exp_data = '0;
        if (op == OP_HIT) begin
            if (!model_valid[line_idx]) begin
                $display("read of 0x%08h expects a hit but its line was never filled", addr);
                check_errors++;
            end
            exp_data = model_line[line_idx][word_idx*32 +: 32];
        end
        check_value("o_rd_data", o_rd_data, exp_data);
        check_value("o_miss", 32'(o_miss), 32'(op == OP_MISS));
        check_value("o_segfault", 32'(o_segfault), 32'(op == OP_FAULT));
    endtask

    // a pending refill always has a nonzero line address.
    task automatic check_request(input logic [31:0] exp);
        check_value("o_rd_req", 32'(o_rd_req), 32'(exp != 0));
        check_value("o_miss_addr", o_miss_addr, exp);
    endtask

    task automatic run_step(input logic [3:0] op, input logic [31:0] addr,
                            input logic [31:0] exp);
        @(posedge clk);
        #DRIVE_DELAY;
        check_result(pipe_op[1], pipe_addr[1]);
        if (pipe_op[2] != OP_BUBBLE)
            check_request(pipe_exp[2]);
        for (int s = 2; s > 0; s--) begin
            pipe_op[s]   = pipe_op[s-1];
            pipe_addr[s] = pipe_addr[s-1];
            pipe_exp[s]  = pipe_exp[s-1];
        end
        pipe_op[0]   = op;
        pipe_addr[0] = addr;
        pipe_exp[0]  = exp;
        i_rd   = (op == OP_HIT || op == OP_MISS || op == OP_FAULT);
        i_addr = i_rd ? addr : '0;
    endtask

    task automatic wait_request();
        int cycles;
        for (cycles = 0; cycles < TIMEOUT_CYCLES && o_rd_req !== 1'b1; cycles++) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        if (o_rd_req !== 1'b1) begin
            $display("timed out waiting for o_rd_req to rise");
            timeout_errors++;
        end
    endtask

    task automatic host_return(input logic [31:0] addr, input logic [31:0] exp);
        logic [LINE_W-1:0] line_data;
        repeat (3) run_step(OP_BUBBLE, '0, '0);  // drain fetches in flight.
        wait_request();
        if (timeout_errors == 0) begin
            for (int b = 0; b < LINE_W; b++) begin
                lfsr         = lfsr_step(lfsr);
                line_data[b] = lfsr[0];
            end
            i_host_rd_ready = 1'b1;
            i_host_rd_addr  = addr;
            i_host_rd_data  = line_data;
            @(posedge clk);
            #DRIVE_DELAY;
            i_host_rd_ready = 1'b0;
            i_host_rd_addr  = '0;
            i_host_rd_data  = '0;
            if (exp == 0) begin
                model_line[int'(addr[8:4])]  = line_data;
                model_valid[int'(addr[8:4])] = 1'b1;
            end
            check_request(exp);
        end
    endtask

    initial begin : main
        int          fd;
        int          status;
        string       text;
        logic [3:0]  op;
        logic [31:0] addr;
        logic [31:0] exp;
        rst_n           = 1'b0;
        i_addr          = '0;
        i_rd            = 1'b0;
        i_host_rd_ready = 1'b0;
        i_host_rd_addr  = '0;
        i_host_rd_data  = '0;
        model_valid     = '0;
        lfsr            = 16'd30;
        check_errors    = 0;
        timeout_errors  = 0;
        for (int s = 0; s < 3; s++) begin
            pipe_op[s]   = OP_BUBBLE;
            pipe_addr[s] = '0;
            pipe_exp[s]  = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        check_result(OP_IDLE, '0);
        check_request('0);
        fd = $fopen("verif/icache_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/icache_stimulus.txt");
            check_errors++;
            finish_run();
        end
        else begin
            while (!$feof(fd) && timeout_errors == 0) begin
                text   = "";
                status = $fgets(text, fd);
                if (status != 0 && $sscanf(text, "%h %h %h", op, addr, exp) == 3) begin
                    if (op == OP_HOST)
                        host_return(addr, exp);
                    else if (op > OP_HOST) begin
                        $display("unknown operation code %0h in stimulus file", op);
                        check_errors++;
                    end
                    else
                        run_step(op, addr, exp);
                end
            end
            $fclose(fd);
            repeat (3) run_step(OP_BUBBLE, '0, '0);
            finish_run();
        end
    end

endmodule

/* src/icache_top.sv */
`timescale 1ns/1ns

module icache_top #(
    parameter int NUM_LINES = 32
) (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic [icache_pkg::WORD_W-1:0]       i_addr,
    input  logic                                i_rd,
    output logic [icache_pkg::WORD_W-1:0]       o_rd_data,
    output logic                                o_miss,
    output logic                                o_segfault,

    input  logic                                i_host_rd_ready,
    input  logic [icache_pkg::WORD_W-1:0]       i_host_rd_addr,
    input  logic [icache_pkg::LINE_W-1:0]       i_host_rd_data,
    output logic                                o_rd_req,
    output logic [icache_pkg::WORD_W-1:0]       o_miss_addr
);

    localparam int IDX_W = $clog2(NUM_LINES);

    logic                                s1_valid;
    logic                                s1_fault;
    logic [icache_pkg::LINE_IDX_W-1:0]   s1_line;
    logic [icache_pkg::WORD_IDX_W-1:0]   s1_word;
    logic [icache_pkg::WORD_W-1:0]       s1_addr;

    logic                                miss_pulse;
    logic [icache_pkg::WORD_W-1:0]       miss_addr;

    logic                                fill_we;
    logic [IDX_W-1:0]                    fill_line;
    logic [icache_pkg::LINE_W-1:0]       fill_data;

    fetch_decode u_fetch_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_addr      (i_addr),
        .i_rd        (i_rd),
        .o_s1_valid  (s1_valid),
        .o_s1_fault  (s1_fault),
        .o_s1_line   (s1_line),
        .o_s1_word   (s1_word),
        .o_s1_addr   (s1_addr)
    );

    icache_store #(
        .NUM_LINES (NUM_LINES)
    ) u_icache_store (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_s1_valid       (s1_valid),
        .i_s1_fault       (s1_fault),
        .i_s1_line        (s1_line),
        .i_s1_word        (s1_word),
        .i_s1_addr        (s1_addr),
        .i_fill_we        (fill_we),
        .i_fill_line      (fill_line),
        .i_fill_data      (fill_data),
        .o_rd_data        (o_rd_data),
        .o_miss           (o_miss),
        .o_segfault       (o_segfault),
        .o_miss_pulse     (miss_pulse),
        .o_miss_addr_line (miss_addr)
    );

    refill_ctrl #(
        .NUM_LINES (NUM_LINES)
    ) u_refill_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_miss_pulse     (miss_pulse),
        .i_miss_addr_line (miss_addr),
        .i_host_rd_ready  (i_host_rd_ready),
        .i_host_rd_addr   (i_host_rd_addr),
        .i_host_rd_data   (i_host_rd_data),
        .o_rd_req         (o_rd_req),
        .o_miss_addr      (o_miss_addr),
        .o_fill_we        (fill_we),
        .o_fill_line      (fill_line),
        .o_fill_data      (fill_data)
    );

endmodule

/* src/refill_ctrl.sv */
`timescale 1ns/1ns

module refill_ctrl #(
    parameter int NUM_LINES = 32
) (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic                                i_miss_pulse,
    input  logic [icache_pkg::WORD_W-1:0]       i_miss_addr_line,

    input  logic                                i_host_rd_ready,
    input  logic [icache_pkg::WORD_W-1:0]       i_host_rd_addr,
    input  logic [icache_pkg::LINE_W-1:0]       i_host_rd_data,

    output logic                                o_rd_req,
    output logic [icache_pkg::WORD_W-1:0]       o_miss_addr,

    output logic                                o_fill_we,
    output logic [$clog2(NUM_LINES)-1:0]        o_fill_line,
    output logic [icache_pkg::LINE_W-1:0]       o_fill_data
);

    localparam int IDX_W = $clog2(NUM_LINES);

    icache_pkg::fetch_addr_u host_addr_u;
    logic                    host_accept;

    assign host_addr_u.raw = i_host_rd_addr;

    // stray or out-of-region returns are dropped.
    assign host_accept = i_host_rd_ready & o_rd_req
                       & icache_pkg::in_region(host_addr_u.raw);

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            o_rd_req    <= 1'b0;
            o_miss_addr <= '0;
            o_fill_we   <= 1'b0;
        end
        else begin
            o_fill_we <= host_accept;
            if (host_accept) begin
                o_rd_req    <= 1'b0;
                o_miss_addr <= '0;
            end
            else if (i_miss_pulse && !o_rd_req) begin
                o_rd_req    <= 1'b1;  // one refill at a time.
                o_miss_addr <= i_miss_addr_line;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (host_accept) begin
            o_fill_line <= host_addr_u.f.line[IDX_W-1:0];
            o_fill_data <= i_host_rd_data;
        end
    end

endmodule

/* src/icache_store.sv */
`timescale 1ns/1ns

module icache_store #(
    parameter int NUM_LINES = 32
) (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic                                i_s1_valid,
    input  logic                                i_s1_fault,
    input  logic [icache_pkg::LINE_IDX_W-1:0]   i_s1_line,
    input  logic [icache_pkg::WORD_IDX_W-1:0]   i_s1_word,
    input  logic [icache_pkg::WORD_W-1:0]       i_s1_addr,

    input  logic                                i_fill_we,
    input  logic [$clog2(NUM_LINES)-1:0]        i_fill_line,
    input  logic [icache_pkg::LINE_W-1:0]       i_fill_data,

    output logic [icache_pkg::WORD_W-1:0]       o_rd_data,
    output logic                                o_miss,
    output logic                                o_segfault,
    output logic                                o_miss_pulse,
    output logic [icache_pkg::WORD_W-1:0]       o_miss_addr_line
);

    localparam int IDX_W = $clog2(NUM_LINES);

    // one entry per line, word n sits at bits 32n+31:32n.
    logic [icache_pkg::LINE_WORDS-1:0][icache_pkg::WORD_W-1:0] lines [NUM_LINES];
    logic [NUM_LINES-1:0]    valid;

    logic [IDX_W-1:0]        rd_idx;
    logic                    line_hit;
    icache_pkg::fetch_addr_u line_addr;

    assign rd_idx   = i_s1_line[IDX_W-1:0];
    assign line_hit = valid[rd_idx];

    always_comb begin
        line_addr        = i_s1_addr;
        line_addr.f.word = '0;  // align to line start.
    end

    // stage 2 result, exactly one of data, miss or fault.
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            o_rd_data  <= '0;
            o_miss     <= 1'b0;
            o_segfault <= 1'b0;
        end
        else begin
            o_segfault <= i_s1_fault;
            o_miss     <= i_s1_valid & ~line_hit;
            if (i_s1_valid && line_hit)
                o_rd_data <= lines[rd_idx][i_s1_word];
            else
                o_rd_data <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_s1_valid && !line_hit)
            o_miss_addr_line <= line_addr.raw;
    end

    assign o_miss_pulse = o_miss;  // refill side watches the same edge.

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            valid <= '0;
        else if (i_fill_we)
            valid[i_fill_line] <= 1'b1;
    end

    // whole line written at once.
    always_ff @(posedge clk) begin
        if (i_fill_we)
            lines[i_fill_line] <= i_fill_data;
    end

endmodule

/* src/fetch_decode.sv */
`timescale 1ns/1ns

module fetch_decode (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic [icache_pkg::WORD_W-1:0]       i_addr,
    input  logic                                i_rd,

    output logic                                o_s1_valid,
    output logic                                o_s1_fault,
    output logic [icache_pkg::LINE_IDX_W-1:0]   o_s1_line,
    output logic [icache_pkg::WORD_IDX_W-1:0]   o_s1_word,
    output logic [icache_pkg::WORD_W-1:0]       o_s1_addr
);

    icache_pkg::fetch_addr_u addr_u;
    logic                    addr_ok;

    assign addr_u.raw = i_addr;
    assign addr_ok    = icache_pkg::in_region(addr_u.raw);

    // stage 1 strobes, low on idle cycles.
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            o_s1_valid <= 1'b0;
            o_s1_fault <= 1'b0;
        end
        else begin
            o_s1_valid <= i_rd & addr_ok;
            o_s1_fault <= i_rd & ~addr_ok;
        end
    end

    // address fields ride along with the strobes.
    always_ff @(posedge clk) begin
        if (i_rd) begin
            o_s1_line <= addr_u.f.line;
            o_s1_word <= addr_u.f.word;
            o_s1_addr <= addr_u.raw;
        end
    end

endmodule

/* src/icache_pkg.sv */
package icache_pkg;

    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 16;
    localparam int LINE_W     = WORD_W * LINE_WORDS;

    localparam int REGION_W   = 23;
    localparam int LINE_IDX_W = 5;
    localparam int WORD_IDX_W = 4;

    // handler region starts at 0x0001_0000, word indexed.
    localparam logic [REGION_W-1:0] REGION_BASE = REGION_W'(32'h0001_0000 >> 9);

    // fetch address, seen as one word or as its fields.
    // byte offset has no bits since addresses count words.
    typedef union packed {
        logic [WORD_W-1:0] raw;
        struct packed {
            logic [REGION_W-1:0]   region;
            logic [LINE_IDX_W-1:0] line;
            logic [WORD_IDX_W-1:0] word;
        } f;
    } fetch_addr_u;

    function automatic logic in_region(input logic [WORD_W-1:0] addr);
        fetch_addr_u a;
        a.raw = addr;
        return (a.f.region == REGION_BASE);
    endfunction

endpackage
